// File: hdl/board_pkg.sv
// Board package with conditioning timing constants and raw input groupings
package board_pkg;

    // Clocks the system reset is held after external reset and PLL lock
    localparam int RST_SYNC_STAGES = 4;

    // Clocks between debounce samples, shortened for simulation
    localparam int DEBOUNCE_RATE = 16;

    // Equal consecutive samples needed before a new level is accepted
    localparam int DEBOUNCE_SAMPLES = 3;

    // Push buttons and slide switches
    typedef struct packed {
        logic       btnu;
        logic       btnl;
        logic       btnd;
        logic       btnr;
        logic       btnc;
        logic [3:0] sw;
    } gpio_in_t;

    // UART receive and flow control
    typedef struct packed {
        logic rxd;
        logic rts;
    } uart_in_t;

    typedef struct packed {
        logic phy_int_n;
        logic clk_chip_int;
    } irq_in_t;

endpackage

// File: hdl/i2c_pkg.sv
// I2C package with write command types, bus timing and the clock chip init table
package i2c_pkg;

    // Clocks per quarter SCL period
    localparam int I2C_QUARTER = 8;

    localparam logic [6:0] CLK_CHIP_ADDR = 7'h68;

    localparam int INIT_LEN = 4;

    // One register write: device address, register address, data
    typedef struct packed {
        logic [6:0] dev_addr;
        logic [7:0] reg_addr;
        logic [7:0] data;
    } i2c_write_t;

    // Set when any byte of the write was not acknowledged
    typedef struct packed {
        logic nack;
    } i2c_result_t;

    typedef struct packed {
        logic [7:0] reg_addr;
        logic [7:0] data;
    } i2c_reg_pair_t;

    // Free run, clock select, output enables, then the calibration trigger
    localparam i2c_reg_pair_t INIT_TABLE [INIT_LEN] = '{
        '{8'h00, 8'h54},
        '{8'h0B, 8'h42},
        '{8'h15, 8'hFE},
        '{8'h88, 8'h40}
    };

endpackage

// File: hdl/reset_sync.sv
// Reset synchronizer with asynchronous assertion and release after PLL lock
`timescale 1ns/1ps

module reset_sync (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic locked_i,
    output logic rst_o
);
    import board_pkg::*;

    logic                       arst_n;
    logic [RST_SYNC_STAGES-1:0] chain_q;

    // Either external reset or loss of lock clears the chain
    assign arst_n = rst_n_i & locked_i;

    always_ff @(posedge clk_i or negedge arst_n) begin
        if (!arst_n) begin
            chain_q <= '1;
        end else begin
            chain_q <= {chain_q[RST_SYNC_STAGES-2:0], 1'b0};
        end
    end

    assign rst_o = chain_q[RST_SYNC_STAGES-1];

endmodule

// File: hdl/signal_sync.sv
// Two-flop synchronizer for a group of asynchronous level inputs
`timescale 1ns/1ps

module signal_sync #(
    parameter type T = logic
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  T     in_i,
    output T     out_o
);

    T meta_q;
    T sync_q;

    // First stage may go metastable, second one settles it
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            meta_q <= '0;
            sync_q <= '0;
        end else begin
            meta_q <= in_i;
            sync_q <= meta_q;
        end
    end

    assign out_o = sync_q;

endmodule

// File: hdl/debounce_switch.sv
// Debouncer that samples buttons and switches at a slow rate and passes stable levels
`timescale 1ns/1ps

module debounce_switch (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  board_pkg::gpio_in_t in_i,
    output board_pkg::gpio_in_t out_o
);
    import board_pkg::*;

    localparam int W  = $bits(gpio_in_t);
    localparam int CW = $clog2(DEBOUNCE_RATE);

    logic [CW-1:0]               rate_cnt;
    logic                        tick;
    logic [W-1:0]                in_bits;
    logic [W-1:0]                out_q;
    logic [DEBOUNCE_SAMPLES-1:0] hist_q [W];

    assign in_bits = in_i;
    assign tick    = (rate_cnt == CW'(DEBOUNCE_RATE - 1));

    // Sample tick generator
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rate_cnt <= '0;
        end else if (tick) begin
            rate_cnt <= '0;
        end else begin
            rate_cnt <= rate_cnt + CW'(1);
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < W; i++) begin
                hist_q[i] <= '0;
            end
            out_q <= '0;
        end else begin
            for (int i = 0; i < W; i++) begin
                if (tick) begin
                    hist_q[i] <= {hist_q[i][DEBOUNCE_SAMPLES-2:0], in_bits[i]};
                end
                // Mixed history keeps the old level
                if (&hist_q[i]) begin
                    out_q[i] <= 1'b1;
                end else if (~|hist_q[i]) begin
                    out_q[i] <= 1'b0;
                end
            end
        end
    end

    assign out_o = gpio_in_t'(out_q);

endmodule

// File: hdl/i2c_write_master.sv
// I2C master for three-byte register writes with clock stretching and nack report
`timescale 1ns/1ps

module i2c_write_master (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 scl_i,
    input  logic                 sda_i,
    input  logic                 cmd_valid_i,
    input  i2c_pkg::i2c_write_t  cmd_i,
    output logic                 cmd_ready_o,
    output logic                 done_o,
    output logic                 scl_o,
    output logic                 sda_o,
    output i2c_pkg::i2c_result_t result_o
);
    import i2c_pkg::*;

    localparam int QW = $clog2(I2C_QUARTER);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_ACK,
        ST_STOP
    } state_t;

    state_t        state;
    logic [QW-1:0] q_cnt;
    logic          q_tick;
    logic          stretch;
    logic [1:0]    phase;
    i2c_write_t    cmd_q;
    logic [1:0]    byte_idx;
    logic [2:0]    bit_cnt;
    logic [7:0]    shift_q;
    logic [7:0]    next_byte;
    logic          ack_bad;
    logic          scl_q;
    logic          sda_q;
    logic          done_q;
    i2c_result_t   result_q;

    // SCL released but a target still holds it low
    assign stretch = scl_q && !scl_i;
    assign q_tick  = (q_cnt == QW'(I2C_QUARTER - 1)) && !stretch;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            q_cnt <= '0;
        end else if (state == ST_IDLE || q_tick) begin
            q_cnt <= '0;
        end else if (!stretch) begin
            q_cnt <= q_cnt + QW'(1);
        end
    end

    always_comb begin
        case (byte_idx)
            2'd0:    next_byte = cmd_q.reg_addr;
            default: next_byte = cmd_q.data;
        endcase
    end

    // Each bit is four quarters: SDA set, SCL up, sample, SCL down
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state    <= ST_IDLE;
            phase    <= '0;
            byte_idx <= '0;
            bit_cnt  <= '0;
            ack_bad  <= 1'b0;
            scl_q    <= 1'b1;
            sda_q    <= 1'b1;
            done_q   <= 1'b0;
            result_q <= '0;
        end else begin
            done_q <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (cmd_valid_i) begin
                        cmd_q    <= cmd_i;
                        byte_idx <= '0;
                        bit_cnt  <= '0;
                        phase    <= '0;
                        ack_bad  <= 1'b0;
                        state    <= ST_START;
                    end
                end
                ST_START: begin
                    if (q_tick) begin
                        if (phase == 2'd0) begin
                            sda_q <= 1'b0;
                            phase <= 2'd1;
                        end else begin
                            scl_q   <= 1'b0;
                            shift_q <= {cmd_q.dev_addr, 1'b0};
                            phase   <= '0;
                            state   <= ST_DATA;
                        end
                    end
                end
                ST_DATA: begin
                    if (q_tick) begin
                        phase <= phase + 2'd1;
                        if (phase == 2'd0) begin
                            sda_q <= shift_q[7];
                        end else if (phase == 2'd1) begin
                            scl_q <= 1'b1;
                        end else if (phase == 2'd3) begin
                            scl_q   <= 1'b0;
                            shift_q <= {shift_q[6:0], 1'b0};
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7) begin
                                state <= ST_ACK;
                            end
                        end
                    end
                end
                ST_ACK: begin
                    if (q_tick) begin
                        phase <= phase + 2'd1;
                        if (phase == 2'd0) begin
                            sda_q <= 1'b1;
                        end else if (phase == 2'd1) begin
                            scl_q <= 1'b1;
                        end else if (phase == 2'd2) begin
                            ack_bad <= sda_i;
                        end else begin
                            scl_q <= 1'b0;
                            if (ack_bad || byte_idx == 2'd2) begin
                                state <= ST_STOP;
                            end else begin
                                shift_q  <= next_byte;
                                byte_idx <= byte_idx + 2'd1;
                                state    <= ST_DATA;
                            end
                        end
                    end
                end
                ST_STOP: begin
                    if (q_tick) begin
                        phase <= phase + 2'd1;
                        if (phase == 2'd0) begin
                            sda_q <= 1'b0;
                        end else if (phase == 2'd1) begin
                            scl_q <= 1'b1;
                        end else if (phase == 2'd2) begin
                            sda_q <= 1'b1;
                        end else begin
                            done_q        <= 1'b1;
                            result_q.nack <= ack_bad;
                            state         <= ST_IDLE;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign cmd_ready_o = (state == ST_IDLE);
    assign done_o      = done_q;
    assign result_o    = result_q;
    assign scl_o       = scl_q;
    assign sda_o       = sda_q;

endmodule

// File: hdl/clk_chip_init.sv
// Init sequencer that writes the clock chip register table over I2C
`timescale 1ns/1ps

module clk_chip_init (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 start_i,
    input  logic                 cmd_ready_i,
    input  logic                 done_i,
    input  i2c_pkg::i2c_result_t result_i,
    output i2c_pkg::i2c_write_t  cmd_o,
    output logic                 cmd_valid_o,
    output logic                 busy_o,
    output logic                 done_o,
    output logic                 error_o
);
    import i2c_pkg::*;

    localparam int IW = (INIT_LEN > 1) ? $clog2(INIT_LEN) : 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SEND,
        ST_WAIT
    } state_t;

    state_t        state;
    logic [IW-1:0] idx;
    logic          done_q;
    logic          error_q;

    // Command follows the table index, so it holds while valid is up
    always_comb begin
        cmd_o.dev_addr = CLK_CHIP_ADDR;
        cmd_o.reg_addr = INIT_TABLE[idx].reg_addr;
        cmd_o.data     = INIT_TABLE[idx].data;
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state   <= ST_IDLE;
            idx     <= '0;
            done_q  <= 1'b0;
            error_q <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start_i) begin
                        idx     <= '0;
                        done_q  <= 1'b0;
                        error_q <= 1'b0;
                        state   <= ST_SEND;
                    end
                end
                ST_SEND: begin
                    if (cmd_ready_i) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (done_i) begin
                        if (result_i.nack) begin
                            // Abandon the rest of the table
                            error_q <= 1'b1;
                            done_q  <= 1'b1;
                            state   <= ST_IDLE;
                        end else if (idx == IW'(INIT_LEN - 1)) begin
                            done_q <= 1'b1;
                            state  <= ST_IDLE;
                        end else begin
                            idx   <= idx + IW'(1);
                            state <= ST_SEND;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign cmd_valid_o = (state == ST_SEND);
    assign busy_o      = (state != ST_IDLE);
    assign done_o      = done_q;
    assign error_o     = error_q;

endmodule

// File: hdl/board_support.sv
// Board support top with reset, input conditioning and clock chip I2C setup
`timescale 1ns/1ps

module board_support (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                pll_locked_i,
    input  board_pkg::gpio_in_t gpio_raw_i,
    input  board_pkg::uart_in_t uart_raw_i,
    input  board_pkg::irq_in_t  irq_raw_i,
    input  logic                init_start_i,
    input  logic                scl_i,
    input  logic                sda_i,
    output logic                sys_rst_o,
    output board_pkg::gpio_in_t gpio_o,
    output board_pkg::uart_in_t uart_o,
    output board_pkg::irq_in_t  irq_o,
    output logic                init_busy_o,
    output logic                init_done_o,
    output logic                init_error_o,
    output logic                scl_o,
    output logic                sda_o,
    output logic                clk_chip_rst_n_o,
    output logic                phy_reset_n_o
);
    import board_pkg::*;
    import i2c_pkg::*;

    logic        sys_rst;
    logic        sys_rst_n;
    i2c_write_t  cmd;
    logic        cmd_valid;
    logic        cmd_ready;
    logic        wr_done;
    i2c_result_t wr_result;

    reset_sync rst_sync (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .locked_i(pll_locked_i),
        .rst_o   (sys_rst)
    );

    assign sys_rst_n        = ~sys_rst;
    assign sys_rst_o        = sys_rst;
    // External chips leave reset together with the core
    assign clk_chip_rst_n_o = sys_rst_n;
    assign phy_reset_n_o    = sys_rst_n;

    debounce_switch gpio_debounce (
        .clk_i  (clk_i),
        .rst_n_i(sys_rst_n),
        .in_i   (gpio_raw_i),
        .out_o  (gpio_o)
    );

    signal_sync #(.T(uart_in_t)) uart_sync (
        .clk_i  (clk_i),
        .rst_n_i(sys_rst_n),
        .in_i   (uart_raw_i),
        .out_o  (uart_o)
    );

    signal_sync #(.T(irq_in_t)) irq_sync (
        .clk_i  (clk_i),
        .rst_n_i(sys_rst_n),
        .in_i   (irq_raw_i),
        .out_o  (irq_o)
    );

    clk_chip_init chip_init (
        .clk_i      (clk_i),
        .rst_n_i    (sys_rst_n),
        .start_i    (init_start_i),
        .cmd_ready_i(cmd_ready),
        .done_i     (wr_done),
        .result_i   (wr_result),
        .cmd_o      (cmd),
        .cmd_valid_o(cmd_valid),
        .busy_o     (init_busy_o),
        .done_o     (init_done_o),
        .error_o    (init_error_o)
    );

    i2c_write_master i2c_master (
        .clk_i      (clk_i),
        .rst_n_i    (sys_rst_n),
        .scl_i      (scl_i),
        .sda_i      (sda_i),
        .cmd_valid_i(cmd_valid),
        .cmd_i      (cmd),
        .cmd_ready_o(cmd_ready),
        .done_o     (wr_done),
        .scl_o      (scl_o),
        .sda_o      (sda_o),
        .result_o   (wr_result)
    );

endmodule

// File: testbench/tb_i2c_target.sv
// I2C target model that acknowledges one device address and logs each register write
`timescale 1ns/1ps

module tb_i2c_target (
    input  logic                clk_i,
    input  logic                ack_en_i,
    input  logic [5:0]          stretch_i,
    input  logic                scl_m_i,
    input  logic                sda_m_i,
    output logic                scl_o,
    output logic                sda_o,
    output i2c_pkg::i2c_write_t wr_o,
    output int                  wr_count_o
);
    import i2c_pkg::*;

    logic       scl_drv  = 1'b1;
    logic       sda_drv  = 1'b1;
    logic       scl_d    = 1'b1;
    logic       sda_d    = 1'b1;
    logic       active   = 1'b0;
    logic       ack_slot = 1'b0;
    int         bit_cnt  = 0;
    int         byte_cnt = 0;
    int         hold_cnt = 0;
    int         count_q  = 0;
    logic [7:0] shift_q  = '0;
    logic [6:0] addr_q   = '0;
    logic [7:0] reg_q    = '0;
    i2c_write_t wr_q     = '0;

    // Pull-ups on both lines, either side can pull low
    assign scl_o      = scl_m_i & scl_drv;
    assign sda_o      = sda_m_i & sda_drv;
    assign wr_o       = wr_q;
    assign wr_count_o = count_q;

    // Lines sampled once per clock, edges found against the previous sample
    always @(posedge clk_i) begin
        scl_d <= scl_o;
        sda_d <= sda_o;
        if (hold_cnt > 0) begin
            hold_cnt <= hold_cnt - 1;
            if (hold_cnt == 1) begin
                scl_drv <= 1'b1;
            end
        end
        if (scl_d && scl_o && sda_d && !sda_o) begin
            // Start condition
            active   <= 1'b1;
            ack_slot <= 1'b0;
            bit_cnt  <= 0;
            byte_cnt <= 0;
        end else if (scl_d && scl_o && !sda_d && sda_o) begin
            // Stop condition
            active   <= 1'b0;
            ack_slot <= 1'b0;
            sda_drv  <= 1'b1;
        end else if (active && !scl_d && scl_o && !ack_slot) begin
            shift_q <= {shift_q[6:0], sda_o};
            bit_cnt <= bit_cnt + 1;
        end else if (active && scl_d && !scl_o) begin
            // Hold SCL low a little longer than the master wants
            if (stretch_i != '0) begin
                scl_drv  <= 1'b0;
                hold_cnt <= int'(stretch_i);
            end
            if (ack_slot) begin
                sda_drv  <= 1'b1;
                ack_slot <= 1'b0;
            end else if (bit_cnt == 8) begin
                bit_cnt  <= 0;
                ack_slot <= 1'b1;
                byte_cnt <= byte_cnt + 1;
                if (byte_cnt == 0 && !(ack_en_i && shift_q == {CLK_CHIP_ADDR, 1'b0})) begin
                    // Not ours or refused, SDA stays released
                    active <= 1'b0;
                end else if (byte_cnt > 2) begin
                    active <= 1'b0;
                end else begin
                    sda_drv <= 1'b0;
                    if (byte_cnt == 0) begin
                        addr_q <= shift_q[7:1];
                    end else if (byte_cnt == 1) begin
                        reg_q <= shift_q;
                    end else begin
                        wr_q    <= '{dev_addr: addr_q, reg_addr: reg_q, data: shift_q};
                        count_q <= count_q + 1;
                    end
                end
            end
        end
    end

endmodule

// File: testbench/tb_board_support.sv
// Testbench for the board support top with reset, conditioning and I2C init tests
`timescale 1ns/1ps

module tb_board_support;
    import board_pkg::*;
    import i2c_pkg::*;

    localparam int CLK_PERIOD  = 8;
    localparam int GPIO_W      = $bits(gpio_in_t);
    localparam int DEB_ROUNDS  = 8;
    localparam int SYNC_ROUNDS = 16;
    localparam int DEB_HOLD    = (DEBOUNCE_SAMPLES + 1) * DEBOUNCE_RATE;
    // Start, three bytes with acknowledge, stop
    localparam int WRITE_CYCLES = (2 + 27 * 4 + 4) * I2C_QUARTER;
    // Start, address byte with acknowledge, stop
    localparam int NACK_CYCLES  = (2 + 9 * 4 + 4) * I2C_QUARTER + 32;
    localparam int STRETCH_MAX  = 64;
    localparam int T_RESET      = 32;
    localparam int T_DEBOUNCE   = DEB_ROUNDS * (DEBOUNCE_RATE + 2 * DEB_HOLD) + 8;
    localparam int T_SYNC       = SYNC_ROUNDS * 4;
    localparam int T_INIT       = INIT_LEN * (WRITE_CYCLES + 16) + 16;
    localparam int T_NACK       = WRITE_CYCLES + T_INIT;
    localparam int T_STRETCH    = INIT_LEN * (WRITE_CYCLES + 28 * STRETCH_MAX + 16) + 16;
    localparam int T_TOTAL      = T_RESET + T_DEBOUNCE + T_SYNC + T_INIT + T_NACK + T_STRETCH;
    localparam int WATCHDOG_NS  = 2 * CLK_PERIOD * T_TOTAL;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        pll_locked;
    gpio_in_t    gpio_raw;
    uart_in_t    uart_raw;
    irq_in_t     irq_raw;
    logic        init_start;
    logic        scl_bus;
    logic        sda_bus;
    logic        scl_m;
    logic        sda_m;
    logic        sys_rst;
    gpio_in_t    gpio;
    uart_in_t    uart;
    irq_in_t     irq;
    logic        init_busy;
    logic        init_done;
    logic        init_error;
    logic        clk_chip_rst_n;
    logic        phy_reset_n;
    logic        ack_en;
    logic [5:0]  stretch_len;
    i2c_write_t  tgt_wr;
    int          tgt_count;
    i2c_write_t  wr_log [$];
    logic [15:0] lfsr_q = 16'd86;
    int          checks = 0;
    int          errors = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    board_support dut0 (
        .clk_i           (clk),
        .rst_n_i         (rst_n),
        .pll_locked_i    (pll_locked),
        .gpio_raw_i      (gpio_raw),
        .uart_raw_i      (uart_raw),
        .irq_raw_i       (irq_raw),
        .init_start_i    (init_start),
        .scl_i           (scl_bus),
        .sda_i           (sda_bus),
        .sys_rst_o       (sys_rst),
        .gpio_o          (gpio),
        .uart_o          (uart),
        .irq_o           (irq),
        .init_busy_o     (init_busy),
        .init_done_o     (init_done),
        .init_error_o    (init_error),
        .scl_o           (scl_m),
        .sda_o           (sda_m),
        .clk_chip_rst_n_o(clk_chip_rst_n),
        .phy_reset_n_o   (phy_reset_n)
    );

    tb_i2c_target tgt0 (
        .clk_i     (clk),
        .ack_en_i  (ack_en),
        .stretch_i (stretch_len),
        .scl_m_i   (scl_m),
        .sda_m_i   (sda_m),
        .scl_o     (scl_bus),
        .sda_o     (sda_bus),
        .wr_o      (tgt_wr),
        .wr_count_o(tgt_count)
    );

    // Collect every write the target reports
    always @(posedge clk) begin
        if (tgt_count > wr_log.size()) begin
            wr_log.push_back(tgt_wr);
        end
    end

    // Galois LFSR with taps 16 14 13 11 that steps once for each bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got 0x%h expected 0x%h at %0t ns", name, got, exp, $time);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        compare_value(name, 32'(got), 32'(exp));
    endtask

    task automatic check_gpio(input string name, input gpio_in_t got, input gpio_in_t exp);
        compare_value(name, 32'(got), 32'(exp));
    endtask

    task automatic check_uart(input string name, input uart_in_t got, input uart_in_t exp);
        compare_value(name, 32'(got), 32'(exp));
    endtask

    task automatic check_irq(input string name, input irq_in_t got, input irq_in_t exp);
        compare_value(name, 32'(got), 32'(exp));
    endtask

    task automatic check_write(input string name, input i2c_write_t got, input i2c_write_t exp);
        compare_value(name, 32'(got), 32'(exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        compare_value(name, got, exp);
    endtask

    task automatic reset_release();
        repeat (6) begin
            @(posedge clk);
            #1;
            check_bit("sys_rst_o", sys_rst, 1'b1);
        end
        pll_locked = 1'b1;
        for (int i = 1; i <= RST_SYNC_STAGES; i++) begin
            @(posedge clk);
            #1;
            check_bit("sys_rst_o", sys_rst, i < RST_SYNC_STAGES);
            check_bit("phy_reset_n_o", phy_reset_n, i >= RST_SYNC_STAGES);
            check_bit("clk_chip_rst_n_o", clk_chip_rst_n, i >= RST_SYNC_STAGES);
        end
    endtask

    // Short bounce toward the new pattern, then the pattern held for good
    task automatic debounce_levels();
        gpio_in_t stable;
        gpio_in_t next;
        int       glitch_len;
        stable = '0;
        check_gpio("gpio_o", gpio, stable);
        for (int r = 0; r < DEB_ROUNDS; r++) begin
            next       = gpio_in_t'(GPIO_W'(random_bits(GPIO_W)));
            glitch_len = 1 + int'(random_bits(4)) % (DEBOUNCE_RATE - 1);
            gpio_raw   = next;
            repeat (glitch_len) @(posedge clk);
            #1;
            gpio_raw = stable;
            repeat (DEB_HOLD) begin
                @(posedge clk);
                #1;
                check_gpio("gpio_o", gpio, stable);
            end
            gpio_raw = next;
            repeat (DEB_HOLD) @(posedge clk);
            #1;
            check_gpio("gpio_o", gpio, next);
            stable = next;
        end
    endtask

    task automatic sync_follow();
        uart_in_t uart_old;
        irq_in_t  irq_old;
        for (int r = 0; r < SYNC_ROUNDS; r++) begin
            uart_old = uart_raw;
            irq_old  = irq_raw;
            uart_raw = uart_in_t'(2'(random_bits(2)));
            irq_raw  = irq_in_t'(2'(random_bits(2)));
            @(posedge clk);
            #1;
            check_uart("uart_o", uart, uart_old);
            check_irq("irq_o", irq, irq_old);
            @(posedge clk);
            #1;
            check_uart("uart_o", uart, uart_raw);
            check_irq("irq_o", irq, irq_raw);
        end
    endtask

    task automatic send_init_table(input logic exp_error, input int exp_writes,
                                   input logic stretch, input int limit);
        int         base;
        int         cycles;
        i2c_write_t exp_wr;
        base       = wr_log.size();
        init_start = 1'b1;
        @(posedge clk);
        #1;
        init_start = 1'b0;
        check_bit("init_busy_o", init_busy, 1'b1);
        cycles = 0;
        while (!init_done && cycles < limit) begin
            if (stretch) begin
                stretch_len = 6'(random_bits(6));
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        stretch_len = '0;
        if (!init_done) begin
            errors++;
            $display("init sequence did not finish within %0d cycles", limit);
        end
        check_bit("init_busy_o", init_busy, 1'b0);
        check_bit("init_done_o", init_done, 1'b1);
        check_bit("init_error_o", init_error, exp_error);
        check_bit("scl_o", scl_m, 1'b1);
        check_bit("sda_o", sda_m, 1'b1);
        check_count("recorded write count", wr_log.size() - base, exp_writes);
        for (int i = 0; i < exp_writes && base + i < wr_log.size(); i++) begin
            exp_wr.dev_addr = CLK_CHIP_ADDR;
            exp_wr.reg_addr = INIT_TABLE[i].reg_addr;
            exp_wr.data     = INIT_TABLE[i].data;
            check_write("recorded write", wr_log[base + i], exp_wr);
        end
    endtask

    task automatic init_sequence();
        send_init_table(1'b0, INIT_LEN, 1'b0, T_INIT);
    endtask

    // Refused address ends the sequence after one address byte, then a clean retry
    task automatic nack_retry();
        ack_en = 1'b0;
        send_init_table(1'b1, 0, 1'b0, NACK_CYCLES);
        ack_en = 1'b1;
        send_init_table(1'b0, INIT_LEN, 1'b0, T_INIT);
    endtask

    task automatic clock_stretch();
        send_init_table(1'b0, INIT_LEN, 1'b1, T_STRETCH);
    endtask

    initial begin
        rst_n       = 1'b0;
        pll_locked  = 1'b0;
        gpio_raw    = '0;
        uart_raw    = '0;
        irq_raw     = '0;
        init_start  = 1'b0;
        ack_en      = 1'b1;
        stretch_len = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        reset_release();
        debounce_levels();
        sync_follow();
        init_sequence();
        nack_retry();
        clock_stretch();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

endmodule

// File: sim.f
hdl/board_pkg.sv
hdl/i2c_pkg.sv
hdl/reset_sync.sv
hdl/signal_sync.sv
hdl/debounce_switch.sv
hdl/i2c_write_master.sv
hdl/clk_chip_init.sv
hdl/board_support.sv
testbench/tb_i2c_target.sv
testbench/tb_board_support.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_board_support
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= Test completed successfully

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
